//--- verilog.f
busPkg.sv
aluPkg.sv
memIf.sv
selectEncode.sv
registerFile.sv
busRegisters.sv
alu.sv
memoryUnit.sv
outPort.sv
dataPath.sv
dataPathTb.sv

//--- Bender.yml
package:
  name: datapath

sources:
  - files:
      - busPkg.sv
      - aluPkg.sv
      - memIf.sv
      - selectEncode.sv
      - registerFile.sv
      - busRegisters.sv
      - alu.sv
      - memoryUnit.sv
      - outPort.sv
      - dataPath.sv
  - target: test
    files:
      - dataPathTb.sv

//--- dataPathTb.sv
// Plays the control unit with default RAM size and latency and counts ALU cycles from the start edge
`timescale 1ns/1ps
`default_nettype none

module dataPathTb;
   import aluPkg::*;

   localparam int MemDepth   = 512;
   localparam int MemLatency = 2;
   localparam int AddrBits   = $clog2(MemDepth);
   localparam int WaitLimit  = 100;

   typedef struct packed {
      logic PCout, IRout, RYout, RZLOout, RZHIout, RHIout;
      logic RLOout, Immout, Inportout, MDRout, MARout, RFout;
      logic PCin, IRin, RYin, RZin, RHIin, RLOin, IncPC;
      logic deviceStrobe, OutportIn, MDRin, MARin, Read, Write, start;
      logic Gra, Grb, Grc, Rin, Rout, BAout, RFin;
   } strobe_t;

   logic        Clock = 1'b0;
   logic        rstN;
   strobe_t     ctl;
   logic [3:0]  rfSelect;
   logic [4:0]  opSelect;
   logic [31:0] deviceIn;
   logic [31:0] deviceOut;
   logic        finished;
   logic        memFinished;
   logic [31:0] regModel [16];
   logic [31:0] memModel [MemDepth];
   int          errors;
   int          timeouts;

   always #10 Clock = ~Clock;

   dataPath #(.MemDepth(MemDepth), .MemLatency(MemLatency)) DUT (
      .Clock(Clock), .rstN(rstN), .PCout(ctl.PCout), .IRout(ctl.IRout), .RYout(ctl.RYout),
      .RZLOout(ctl.RZLOout), .RZHIout(ctl.RZHIout), .RHIout(ctl.RHIout),
      .RLOout(ctl.RLOout), .Immout(ctl.Immout), .Inportout(ctl.Inportout),
      .MDRout(ctl.MDRout), .MARout(ctl.MARout), .RFout(ctl.RFout), .PCin(ctl.PCin),
      .IRin(ctl.IRin), .RYin(ctl.RYin), .RZin(ctl.RZin), .RHIin(ctl.RHIin),
      .RLOin(ctl.RLOin), .IncPC(ctl.IncPC), .deviceStrobe(ctl.deviceStrobe),
      .OutportIn(ctl.OutportIn), .MDRin(ctl.MDRin), .MARin(ctl.MARin), .Read(ctl.Read),
      .Write(ctl.Write), .start(ctl.start), .Gra(ctl.Gra), .Grb(ctl.Grb), .Grc(ctl.Grc),
      .Rin(ctl.Rin), .Rout(ctl.Rout), .BAout(ctl.BAout), .RFin(ctl.RFin),
      .RFSelect(rfSelect), .opSelect(opSelect), .deviceIn(deviceIn),
      .deviceOut(deviceOut), .finished(finished), .memFinished(memFinished)
   );

   // Expected ALU result, high word first
   function automatic logic [63:0] aluModel(input aluOp_t op, input logic [31:0] a,
                                            input logic [31:0] b);
      logic [63:0] twice;
      logic [4:0]  n;
      longint      product;
      int          quotient;
      int          remainder;
      n = b[4:0];
      quotient = 0;
      remainder = 0;
      case (op)
         opAdd:   return {32'd0, a + b};
         opSub:   return {32'd0, a - b};
         opAnd:   return {32'd0, a & b};
         opOr:    return {32'd0, a | b};
         opShr:   return {32'd0, a >> n};
         opShra:  return {32'd0, 32'($signed(a) >>> n)};
         opShl:   return {32'd0, a << n};
         opRor: begin
            twice = {a, a} >> n;
            return {32'd0, twice[31:0]};
         end
         opRol: begin
            twice = {a, a} << n;
            return {32'd0, twice[63:32]};
         end
         opMul: begin
            product = longint'($signed(a)) * longint'($signed(b));
            return product;
         end
         opDiv: begin
            // Quotient low, remainder high, both truncated toward zero
            quotient = $signed(a) / $signed(b);
            remainder = $signed(a) % $signed(b);
            return {remainder, quotient};
         end
         opNeg:   return {32'd0, -b};
         opNot:   return {32'd0, ~b};
         default: return '0;
      endcase
   endfunction

   // Strobes of the last step drop here
   task automatic nextStep();
      @(posedge Clock);
      ctl <= '0;
   endtask

   task automatic loadInport(input logic [31:0] value);
      nextStep();
      deviceIn <= value;
      ctl.deviceStrobe <= 1'b1;
   endtask

   task automatic inportToRegister(input logic [3:0] index);
      nextStep();
      rfSelect <= index;
      ctl.Inportout <= 1'b1;
      ctl.RFin <= 1'b1;
   endtask

   task automatic registerToOutport(input logic [3:0] index);
      nextStep();
      rfSelect <= index;
      ctl.RFout <= 1'b1;
      ctl.OutportIn <= 1'b1;
   endtask

   task automatic baseToOutport();
      nextStep();
      ctl.Grb <= 1'b1;
      ctl.BAout <= 1'b1;
      ctl.OutportIn <= 1'b1;
   endtask

   task automatic inportToMar();
      nextStep();
      ctl.Inportout <= 1'b1;
      ctl.MARin <= 1'b1;
   endtask

   task automatic inportToMdr();
      nextStep();
      ctl.Inportout <= 1'b1;
      ctl.MDRin <= 1'b1;
   endtask

   task automatic inportToY();
      nextStep();
      ctl.Inportout <= 1'b1;
      ctl.RYin <= 1'b1;
   endtask

   task automatic inportToPc();
      nextStep();
      ctl.Inportout <= 1'b1;
      ctl.PCin <= 1'b1;
   endtask

   task automatic inportToAlu(input aluOp_t op);
      nextStep();
      opSelect <= op;
      ctl.Inportout <= 1'b1;
      ctl.start <= 1'b1;
   endtask

   task automatic immediateToAlu();
      nextStep();
      opSelect <= opAdd;
      ctl.Immout <= 1'b1;
      ctl.start <= 1'b1;
   endtask

   task automatic mdrToOutport();
      nextStep();
      ctl.MDRout <= 1'b1;
      ctl.OutportIn <= 1'b1;
   endtask

   task automatic mdrToIr();
      nextStep();
      ctl.MDRout <= 1'b1;
      ctl.IRin <= 1'b1;
   endtask

   task automatic mdrToRa();
      nextStep();
      ctl.MDRout <= 1'b1;
      ctl.Gra <= 1'b1;
      ctl.Rin <= 1'b1;
   endtask

   task automatic pcToMar();
      nextStep();
      ctl.PCout <= 1'b1;
      ctl.MARin <= 1'b1;
      ctl.IncPC <= 1'b1;
   endtask

   task automatic pcToOutport();
      nextStep();
      ctl.PCout <= 1'b1;
      ctl.OutportIn <= 1'b1;
   endtask

   task automatic baseToY();
      nextStep();
      ctl.Grb <= 1'b1;
      ctl.BAout <= 1'b1;
      ctl.RYin <= 1'b1;
   endtask

   task automatic loadZ();
      nextStep();
      ctl.RZin <= 1'b1;
   endtask

   task automatic zToMar();
      nextStep();
      ctl.RZLOout <= 1'b1;
      ctl.MARin <= 1'b1;
   endtask

   task automatic zToOutport(input logic high);
      nextStep();
      ctl.RZLOout <= !high;
      ctl.RZHIout <= high;
      ctl.OutportIn <= 1'b1;
   endtask

   // Strobes stay up until memFinished shows in a low clock phase
   task automatic waitMemory(input string what);
      int cycles;
      for (cycles = 1; cycles <= WaitLimit; cycles++) begin
         @(negedge Clock);
         if (memFinished) break;
      end
      if (cycles > WaitLimit) begin
         timeouts++;
         $display("Timeout: memFinished never rose during the %s", what);
      end else begin
         assert (cycles <= MemLatency + 2) else begin
            errors++;
            $display("Fail at %0t ns: %s took %0d cycles", $time, what, cycles);
         end
      end
   endtask

   task automatic holdWrite();
      nextStep();
      ctl.Write <= 1'b1;
      waitMemory("memory write");
   endtask

   task automatic holdRead();
      nextStep();
      ctl.Read <= 1'b1;
      ctl.MDRin <= 1'b1;
      waitMemory("memory read");
   endtask

   // Start lasts one step and the count begins at the edge that samples it
   task automatic waitAlu(input int expected, input string what);
      int cycles;
      nextStep();
      for (cycles = 1; cycles <= WaitLimit; cycles++) begin
         @(negedge Clock);
         if (finished) break;
      end
      if (cycles > WaitLimit) begin
         timeouts++;
         $display("Timeout: finished never rose for %s", what);
      end else begin
         assert (cycles == expected) else begin
            errors++;
            $display("Fail at %0t ns: %s finished after %0d cycles, expected %0d",
                     $time, what, cycles, expected);
         end
      end
   endtask

   task automatic checkDeviceOut(input logic [31:0] expected, input string what);
      nextStep();
      @(negedge Clock);
      assert (deviceOut === expected) else begin
         errors++;
         $display("Fail at %0t ns: %s gave %h, expected %h", $time, what, deviceOut, expected);
      end
   endtask

   task automatic writeRegister(input logic [3:0] index, input logic [31:0] value);
      loadInport(value);
      inportToRegister(index);
      regModel[index] = value;
   endtask

   task automatic writeMemory(input logic [31:0] address, input logic [31:0] data);
      loadInport(address);
      inportToMar();
      loadInport(data);
      inportToMdr();
      holdWrite();
      memModel[address[AddrBits-1:0]] = data;
   endtask

   // MDR is spoiled first so a read that loads nothing shows up
   task automatic readMemory(input logic [31:0] address);
      loadInport(address);
      inportToMar();
      loadInport(~memModel[address[AddrBits-1:0]]);
      inportToMdr();
      holdRead();
      mdrToOutport();
      checkDeviceOut(memModel[address[AddrBits-1:0]], "memory read back");
   endtask

   task automatic runAlu(input aluOp_t op, input logic [31:0] a, input logic [31:0] b);
      logic [63:0] expected;
      logic        isLong;
      expected = aluModel(op, a, b);
      isLong = (op == opMul) || (op == opDiv);
      loadInport(a);
      inportToY();
      loadInport(b);
      inportToAlu(op);
      waitAlu(isLong ? 33 : 1, $sformatf("ALU op %0d", op));
      loadZ();
      zToOutport(1'b0);
      checkDeviceOut(expected[31:0], $sformatf("Z low of ALU op %0d", op));
      zToOutport(1'b1);
      checkDeviceOut(expected[63:32], $sformatf("Z high of ALU op %0d", op));
   endtask

   // ld Ra, C(Rb) walked through fetch and execute
   task automatic runLoad(input logic [3:0] rb);
      logic [3:0]  ra;
      logic [18:0] c;
      logic [31:0] pc;
      logic [31:0] base;
      logic [31:0] address;
      logic [31:0] word;
      ra = 4'($urandom_range(1, 15));
      while (ra == rb) begin
         ra = 4'($urandom_range(1, 15));
      end
      writeRegister(rb, $urandom() | 32'h1);
      base = (rb == 4'd0) ? 32'd0 : regModel[rb];
      c = 19'($urandom());
      address = base + {{13{c[18]}}, c};
      pc = $urandom();
      while (pc[AddrBits-1:0] == address[AddrBits-1:0]) begin
         pc = pc + 32'd1;
      end
      word = $urandom();
      writeMemory(address, word);
      writeMemory(pc, {5'd0, ra, rb, c});
      loadInport(pc);
      inportToPc();
      pcToMar();
      holdRead();
      mdrToIr();
      baseToY();
      immediateToAlu();
      waitAlu(1, "address add");
      loadZ();
      zToMar();
      holdRead();
      mdrToRa();
      regModel[ra] = word;
      registerToOutport(ra);
      checkDeviceOut(regModel[ra], $sformatf("load into R%0d with base R%0d", ra, rb));
      pcToOutport();
      checkDeviceOut(pc + 32'd1, "PC after fetch");
   endtask

   initial begin
      logic [3:0]  index;
      logic [31:0] a;
      logic [31:0] b;
      aluOp_t      op;
      void'($urandom(30370));
      errors = 0;
      timeouts = 0;
      ctl = '0;
      rfSelect = '0;
      opSelect = '0;
      deviceIn = '0;
      rstN = 1'b0;
      for (int i = 0; i < 16; i++) begin
         regModel[i] = '0;
      end
      repeat (5) @(posedge Clock);
      rstN <= 1'b1;

      @(negedge Clock);
      assert (deviceOut === '0 && finished === 1'b0 && memFinished === 1'b0) else begin
         errors++;
         $display("Fail at %0t ns: after reset deviceOut %h finished %b memFinished %b",
                  $time, deviceOut, finished, memFinished);
      end

      // IR is still zero here, so Grb selects register 0
      index = 4'($urandom_range(1, 15));
      writeRegister(index, $urandom());
      registerToOutport(index);
      checkDeviceOut(regModel[index], $sformatf("R%0d read", index));
      writeRegister(4'd0, $urandom() | 32'h1);
      registerToOutport(4'd0);
      checkDeviceOut(regModel[0], "R0 direct read");
      baseToOutport();
      checkDeviceOut(32'd0, "R0 read with BAout");

      repeat (4) begin
         a = $urandom();
         writeMemory(a, $urandom());
         readMemory(a);
      end

      for (int code = opAdd; code <= opNot; code++) begin
         op = aluOp_t'(code);
         a = $urandom();
         b = $urandom();
         if (op == opShr || op == opShra || op == opShl || op == opRor || op == opRol) begin
            b = $urandom_range(31);
         end
         if (op == opDiv && b == 32'd0) begin
            b = 32'd1;
         end
         runAlu(op, a, b);
      end

      runLoad(4'($urandom_range(1, 15)));
      runLoad(4'd0);

      $display("Errors: %0d, timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- dataPath.sv
// Control strobes come from outside one micro-step per clock with no handshake
`timescale 1ns/1ps
`default_nettype none

module dataPath #(
   parameter int MemDepth   = 512,
   parameter int MemLatency = 2
) (
   input  logic        Clock,
   input  logic        rstN,
   input  logic        PCout,
   input  logic        IRout,
   input  logic        RYout,
   input  logic        RZLOout,
   input  logic        RZHIout,
   input  logic        RHIout,
   input  logic        RLOout,
   input  logic        Immout,
   input  logic        Inportout,
   input  logic        MDRout,
   input  logic        MARout,
   input  logic        RFout,
   input  logic        PCin,
   input  logic        IRin,
   input  logic        RYin,
   input  logic        RZin,
   input  logic        RHIin,
   input  logic        RLOin,
   input  logic        IncPC,
   input  logic        deviceStrobe,
   input  logic        OutportIn,
   input  logic        MDRin,
   input  logic        MARin,
   input  logic        Read,
   input  logic        Write,
   input  logic        start,
   input  logic        Gra,
   input  logic        Grb,
   input  logic        Grc,
   input  logic        Rin,
   input  logic        Rout,
   input  logic        BAout,
   input  logic        RFin,
   input  logic [3:0]  RFSelect,
   input  logic [4:0]  opSelect,
   input  logic [31:0] deviceIn,
   output logic [31:0] deviceOut,
   output logic        finished,
   output logic        memFinished
);
   import busPkg::*;
   import aluPkg::*;

   busWord_t   bus;
   busWord_t   ir;
   busWord_t   y;
   busWord_t   rfData;
   busWord_t   immediate;
   regIndex_t  regIndex;
   logic       regWrite;
   logic       forceZero;
   aluResult_t aluResult;

   memIf mem ();

   selectEncode uSelect (
      .ir(ir), .gra(Gra), .grb(Grb), .grc(Grc), .rin(Rin), .rout(Rout), .baOut(BAout),
      .rfIn(RFin), .rfOut(RFout), .rfSelect(RFSelect), .regIndex(regIndex),
      .regWrite(regWrite), .forceZero(forceZero), .immediate(immediate)
   );

   registerFile uRegs (
      .Clock(Clock), .rstN(rstN), .regIndex(regIndex), .regWrite(regWrite),
      .forceZero(forceZero), .writeData(bus), .readData(rfData)
   );

   // Any register read strobe puts the file on the bus
   busRegisters uBusRegs (
      .Clock(Clock), .rstN(rstN), .PCout(PCout), .IRout(IRout), .RYout(RYout),
      .RZLOout(RZLOout), .RZHIout(RZHIout), .RHIout(RHIout), .RLOout(RLOout),
      .Immout(Immout), .Inportout(Inportout), .MDRout(MDRout), .MARout(MARout),
      .RFout(RFout | Rout | BAout), .PCin(PCin), .IRin(IRin), .RYin(RYin), .RZin(RZin),
      .RHIin(RHIin), .RLOin(RLOin), .IncPC(IncPC), .deviceStrobe(deviceStrobe),
      .Read(Read), .Write(Write), .deviceIn(deviceIn), .rfData(rfData),
      .immediate(immediate), .aluResult(aluResult), .mem(mem), .bus(bus), .ir(ir), .y(y)
   );

   alu uAlu (
      .Clock(Clock), .rstN(rstN), .start(start), .opSelect(aluOp_t'(opSelect)),
      .a(y), .b(bus), .result(aluResult), .finished(finished)
   );

   // MAR and MDR reach the bus through mem
   memoryUnit #(.MemDepth(MemDepth), .MemLatency(MemLatency)) uMem (
      .Clock(Clock), .rstN(rstN), .MARin(MARin), .MDRin(MDRin), .bus(bus), .mem(mem),
      .mar(), .mdr(), .memFinished(memFinished)
   );

   outPort uOutPort (
      .Clock(Clock), .rstN(rstN), .OutportIn(OutportIn), .bus(bus), .deviceOut(deviceOut)
   );

endmodule

`default_nettype wire

//--- outPort.sv
// deviceOut follows the bus one edge after OutportIn and holds until the next load
`timescale 1ns/1ps
`default_nettype none

module outPort (
   input  logic             Clock,
   input  logic             rstN,
   input  logic             OutportIn,
   input  busPkg::busWord_t bus,
   output busPkg::busWord_t deviceOut
);
   import busPkg::*;

   busWord_t outReg;

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         outReg <= '0;
      end else if (OutportIn) begin
         outReg <= bus;
      end
   end

   assign deviceOut = outReg;

endmodule

`default_nettype wire

//--- memoryUnit.sv
// MemLatency must be at least 1 and only the low MAR bits address the RAM
`timescale 1ns/1ps
`default_nettype none

module memoryUnit #(
   parameter int MemDepth   = 512,
   parameter int MemLatency = 2
) (
   input  logic             Clock,
   input  logic             rstN,
   input  logic             MARin,
   input  logic             MDRin,
   input  busPkg::busWord_t bus,
   memIf.ram                mem,
   output busPkg::busWord_t mar,
   output busPkg::busWord_t mdr,
   output logic             memFinished
);
   import busPkg::*;

   localparam int AddrBits  = $clog2(MemDepth);
   localparam int CountBits = $clog2(MemLatency + 1);

   busWord_t             ram [MemDepth];
   logic [AddrBits-1:0]  ramAddr;
   logic [CountBits-1:0] latencyCount;
   logic                 done;
   logic                 accessEnds;

   assign ramAddr    = mar[AddrBits-1:0];
   assign accessEnds = !done && (mem.read || mem.write) &&
                       (latencyCount == CountBits'(MemLatency - 1));

   // Latency counter, done is a single-cycle pulse
   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         latencyCount <= '0;
         done         <= 1'b0;
      end else if (done || !(mem.read || mem.write)) begin
         latencyCount <= '0;
         done         <= 1'b0;
      end else if (accessEnds) begin
         done <= 1'b1;
      end else begin
         latencyCount <= latencyCount + 1'b1;
      end
   end

   always_ff @(posedge Clock) begin
      if (accessEnds && mem.write) begin
         ram[ramAddr] <= mdr;
      end
   end

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         mar <= '0;
         mdr <= '0;
      end else begin
         if (MARin) mar <= bus;
         // Bus load outside a read, RAM load when the read completes
         if (MDRin && !mem.read) begin
            mdr <= mem.writeData;
         end else if (MDRin && mem.read && done) begin
            mdr <= ram[ramAddr];
         end
      end
   end

   assign mem.address  = mar;
   assign mem.readData = mdr;
   assign mem.done     = done;
   assign memFinished  = done;

endmodule

`default_nettype wire

//--- alu.sv
// Operand A is Y and B is the bus while neg and not act on B alone and start is ignored while busy
`timescale 1ns/1ps
`default_nettype none

module alu (
   input  logic               Clock,
   input  logic               rstN,
   input  logic               start,
   input  aluPkg::aluOp_t     opSelect,
   input  busPkg::busWord_t   a,
   input  busPkg::busWord_t   b,
   output aluPkg::aluResult_t result,
   output logic               finished
);
   import busPkg::*;
   import aluPkg::*;

   localparam int Steps = BusWidth;
   localparam int ShiftBits = $clog2(BusWidth);

   logic                     busy;
   logic                     isDiv;
   logic                     negLow;
   logic                     negHigh;
   logic [$clog2(Steps)-1:0] stepCount;
   busWord_t                 workHi;
   busWord_t                 workLo;
   busWord_t                 stepOperand;
   busWord_t                 magA;
   busWord_t                 magB;
   busWord_t                 quickLow;
   busWord_t                 nextHi;
   busWord_t                 nextLo;
   logic [BusWidth:0]        mulSum;
   logic [BusWidth:0]        divShift;
   logic [BusWidth:0]        divTrial;
   aluResult_t               finalResult;

   always_comb begin
      magA = a[BusWidth-1] ? -a : a;
      magB = b[BusWidth-1] ? -b : b;
      case (opSelect)
         opAdd:   quickLow = a + b;
         opSub:   quickLow = a - b;
         opAnd:   quickLow = a & b;
         opOr:    quickLow = a | b;
         opShr:   quickLow = a >> b[ShiftBits-1:0];
         opShra:  quickLow = $signed(a) >>> b[ShiftBits-1:0];
         opShl:   quickLow = a << b[ShiftBits-1:0];
         opRor:   quickLow = (a >> b[ShiftBits-1:0]) | (a << (BusWidth - b[ShiftBits-1:0]));
         opRol:   quickLow = (a << b[ShiftBits-1:0]) | (a >> (BusWidth - b[ShiftBits-1:0]));
         opNeg:   quickLow = -b;
         opNot:   quickLow = ~b;
         default: quickLow = '0;
      endcase
   end

   // One shift-add or restoring-divide step on magnitudes
   always_comb begin
      mulSum   = {1'b0, workHi} + (workLo[0] ? {1'b0, stepOperand} : '0);
      divShift = {workHi, workLo[BusWidth-1]};
      divTrial = divShift - {1'b0, stepOperand};
      if (!isDiv) begin
         nextHi = mulSum[BusWidth:1];
         nextLo = {mulSum[0], workLo[BusWidth-1:1]};
      end else if (!divTrial[BusWidth]) begin
         nextHi = divTrial[BusWidth-1:0];
         nextLo = {workLo[BusWidth-2:0], 1'b1};
      end else begin
         nextHi = divShift[BusWidth-1:0];
         nextLo = {workLo[BusWidth-2:0], 1'b0};
      end
      // Signs restored on the last step
      if (isDiv) begin
         finalResult.lo = negLow ? -nextLo : nextLo;
         finalResult.hi = negHigh ? -nextHi : nextHi;
      end else begin
         finalResult = negLow ? -{nextHi, nextLo} : {nextHi, nextLo};
      end
   end

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         busy        <= 1'b0;
         isDiv       <= 1'b0;
         negLow      <= 1'b0;
         negHigh     <= 1'b0;
         stepCount   <= '0;
         workHi      <= '0;
         workLo      <= '0;
         stepOperand <= '0;
         result      <= '0;
         finished    <= 1'b0;
      end else begin
         finished <= 1'b0;
         if (busy) begin
            workHi    <= nextHi;
            workLo    <= nextLo;
            stepCount <= stepCount + 1'b1;
            if (stepCount == Steps - 1) begin
               busy     <= 1'b0;
               result   <= finalResult;
               finished <= 1'b1;
            end
         end else if (start) begin
            stepCount <= '0;
            negLow    <= a[BusWidth-1] ^ b[BusWidth-1];
            negHigh   <= a[BusWidth-1];
            workHi    <= '0;
            case (opSelect)
               opMul: begin
                  busy        <= 1'b1;
                  isDiv       <= 1'b0;
                  workLo      <= magB;
                  stepOperand <= magA;
               end
               opDiv: begin
                  busy        <= 1'b1;
                  isDiv       <= 1'b1;
                  workLo      <= magA;
                  stepOperand <= magB;
               end
               default: begin
                  result.hi <= '0;
                  result.lo <= quickLow;
                  finished  <= 1'b1;
               end
            endcase
         end
      end
   end

endmodule

`default_nettype wire

//--- busRegisters.sv
// Only one out strobe is expected per step and overlaps resolve by fixed priority
`timescale 1ns/1ps
`default_nettype none

module busRegisters (
   input  logic               Clock,
   input  logic               rstN,
   input  logic               PCout,
   input  logic               IRout,
   input  logic               RYout,
   input  logic               RZLOout,
   input  logic               RZHIout,
   input  logic               RHIout,
   input  logic               RLOout,
   input  logic               Immout,
   input  logic               Inportout,
   input  logic               MDRout,
   input  logic               MARout,
   input  logic               RFout,
   input  logic               PCin,
   input  logic               IRin,
   input  logic               RYin,
   input  logic               RZin,
   input  logic               RHIin,
   input  logic               RLOin,
   input  logic               IncPC,
   input  logic               deviceStrobe,
   input  logic               Read,
   input  logic               Write,
   input  busPkg::busWord_t   deviceIn,
   input  busPkg::busWord_t   rfData,
   input  busPkg::busWord_t   immediate,
   input  aluPkg::aluResult_t aluResult,
   memIf.master               mem,
   output busPkg::busWord_t   bus,
   output busPkg::busWord_t   ir,
   output busPkg::busWord_t   y
);
   import busPkg::*;
   import aluPkg::*;

   busWord_t   pc;
   busWord_t   hi;
   busWord_t   lo;
   busWord_t   inport;
   aluResult_t z;

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         pc     <= '0;
         ir     <= '0;
         y      <= '0;
         z      <= '0;
         hi     <= '0;
         lo     <= '0;
         inport <= '0;
      end else begin
         // A direct load takes precedence over the increment
         if (PCin) begin
            pc <= bus;
         end else if (IncPC) begin
            pc <= pc + 1'b1;
         end
         if (IRin) ir <= bus;
         if (RYin) y <= bus;
         if (RZin) z <= aluResult;
         if (RHIin) hi <= bus;
         if (RLOin) lo <= bus;
         if (deviceStrobe) inport <= deviceIn;
      end
   end

   // Bus source, earlier strobe wins, idle bus reads zero
   always_comb begin
      if (RFout) bus = rfData;
      else if (PCout) bus = pc;
      else if (IRout) bus = ir;
      else if (RYout) bus = y;
      else if (RZLOout) bus = z.lo;
      else if (RZHIout) bus = z.hi;
      else if (MARout) bus = mem.address;
      else if (RHIout) bus = hi;
      else if (RLOout) bus = lo;
      else if (Immout) bus = immediate;
      else if (Inportout) bus = inport;
      else if (MDRout) bus = mem.readData;
      else bus = '0;
   end

   assign mem.read      = Read;
   assign mem.write     = Write;
   assign mem.writeData = bus;

endmodule

`default_nettype wire

//--- registerFile.sv
// Single shared port so a step either reads or writes one register
`timescale 1ns/1ps
`default_nettype none

module registerFile (
   input  logic              Clock,
   input  logic              rstN,
   input  busPkg::regIndex_t regIndex,
   input  logic              regWrite,
   input  logic              forceZero,
   input  busPkg::busWord_t  writeData,
   output busPkg::busWord_t  readData
);
   import busPkg::*;

   busWord_t regs [RegCount];

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < RegCount; i++) begin
            regs[i] <= '0;
         end
      end else if (regWrite) begin
         regs[regIndex] <= writeData;
      end
   end

   // BAout on register 0 reads as zero
   assign readData = forceZero ? '0 : regs[regIndex];

endmodule

`default_nettype wire

//--- selectEncode.sv
// Gra beats Grb beats Grc and a read strobe in the same step blocks the register write
`timescale 1ns/1ps
`default_nettype none

module selectEncode (
   input  busPkg::busWord_t  ir,
   input  logic              gra,
   input  logic              grb,
   input  logic              grc,
   input  logic              rin,
   input  logic              rout,
   input  logic              baOut,
   input  logic              rfIn,
   input  logic              rfOut,
   input  busPkg::regIndex_t rfSelect,
   output busPkg::regIndex_t regIndex,
   output logic              regWrite,
   output logic              forceZero,
   output busPkg::busWord_t  immediate
);
   import busPkg::*;

   logic portRead;

   // IR fields override the direct select
   always_comb begin
      if (gra) begin
         regIndex = ir[RaMsb:RaLsb];
      end else if (grb) begin
         regIndex = ir[RbMsb:RbLsb];
      end else if (grc) begin
         regIndex = ir[RcMsb:RcLsb];
      end else begin
         regIndex = rfSelect;
      end
   end

   // One port, so a read owns it for the step
   assign portRead  = rout | rfOut | baOut;
   assign regWrite  = (rin | rfIn) & ~portRead;
   assign forceZero = baOut && (regIndex == '0);

   assign immediate = {{(BusWidth - ConstMsb - 1){ir[ConstMsb]}}, ir[ConstMsb:ConstLsb]};

endmodule

`default_nettype wire

//--- memIf.sv
// The RAM side returns MAR and MDR on address and readData so the bus can select them
`timescale 1ns/1ps
`default_nettype none

interface memIf;

   import busPkg::*;

   busWord_t address;
   busWord_t writeData;
   busWord_t readData;
   logic     read;
   logic     write;
   logic     done;

   // Read or write stays high until done pulses for one cycle
   modport master (output read, write, writeData, input address, readData, done);
   modport ram (input read, write, writeData, output address, readData, done);

endinterface

`default_nettype wire

//--- aluPkg.sv
// ALU codes start at 4 for add as on the existing control strobes and the result is 64 bits
`default_nettype none

package aluPkg;

   import busPkg::*;

   typedef enum logic [4:0] {
      opAdd  = 5'd4,
      opSub  = 5'd5,
      opAnd  = 5'd6,
      opOr   = 5'd7,
      opShr  = 5'd8,
      opShra = 5'd9,
      opShl  = 5'd10,
      opRor  = 5'd11,
      opRol  = 5'd12,
      opMul  = 5'd13,
      opDiv  = 5'd14,
      opNeg  = 5'd15,
      opNot  = 5'd16
   } aluOp_t;

   // High word holds the product top half or the remainder
   typedef struct packed {
      busWord_t hi;
      busWord_t lo;
   } aluResult_t;

endpackage

`default_nettype wire

//--- busPkg.sv
// Assumes a 32-bit word, sixteen registers and the fixed instruction field layout of the CPU
`default_nettype none

package busPkg;

   localparam int BusWidth = 32;
   localparam int RegCount = 16;

   typedef logic [BusWidth-1:0] busWord_t;
   typedef logic [$clog2(RegCount)-1:0] regIndex_t;

   // Instruction field positions
   localparam int OpcodeMsb = 31;
   localparam int OpcodeLsb = 27;
   localparam int RaMsb = 26;
   localparam int RaLsb = 23;
   localparam int RbMsb = 22;
   localparam int RbLsb = 19;
   localparam int RcMsb = 18;
   localparam int RcLsb = 15;
   localparam int ConstMsb = 18;
   localparam int ConstLsb = 0;

endpackage

`default_nettype wire
